/* src/cfgreg_pkg.sv */
`default_nettype none

package cfgreg_pkg;

    localparam int XLEN = 32;                             // Core address and data width

    typedef logic [XLEN-1:0] addr_t;                      // Core and DDR byte address
    typedef logic [31:0]     word_t;                      // APB data word
    typedef logic [15:0]     paddr_t;                     // APB address
    typedef logic [11:0]     reg_off_t;                   // Register offset inside a region
    typedef logic [3:0]      region_t;                    // Region select from paddr[15:12]
    typedef logic [31:0]     cnt_t;                       // Wrapping statistics counter

    // Region map of the APB space
    localparam region_t REGION_CFG   = 4'd0;
    localparam region_t REGION_REMAP = 4'd1;

    localparam reg_off_t CFGREG_RSTN      = 12'h000;
    localparam reg_off_t CFGREG_BOOTVEC   = 12'h004;
    localparam reg_off_t CFGREG_DDROFFSET = 12'h008;
    localparam reg_off_t CFGREG_RSVREG0   = 12'h00C;
    localparam reg_off_t CFGREG_RSVREG1   = 12'h010;
    localparam reg_off_t CFGREG_VER       = 12'h014;   // Read only

    localparam reg_off_t REMAP_HITCNT    = 12'h000;
    localparam reg_off_t REMAP_FAULTCNT  = 12'h004;
    localparam reg_off_t REMAP_FAULTADDR = 12'h008;

    localparam addr_t DDR_OFFSET_RST = 32'h2000_0000;
    localparam addr_t BOOTVEC_RST    = 32'h0000_0000;
    localparam word_t RISCV_VER      = 32'h0001_0200;   // Major 1, minor 2, patch 0

    // Core side DDR window, translated by ddr_remap
    localparam addr_t DDR_WIN_BASE = 32'h8000_0000;
    localparam addr_t DDR_WIN_SIZE = 32'h1000_0000;

endpackage

`default_nettype wire

/* src/apb_intf.sv */
`timescale 1ns/1ns
`default_nettype none

interface apb_intf;
    import cfgreg_pkg::*;

    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    word_t  pwdata;
    word_t  prdata;
    logic   pready;
    logic   pslverr;

    modport master (
        output psel,
        output penable,
        output pwrite,
        output paddr,
        output pwdata,
        input  prdata,
        input  pready,
        input  pslverr
    );

    modport slave (
        input  psel,
        input  penable,
        input  pwrite,
        input  paddr,
        input  pwdata,
        output prdata,
        output pready,
        output pslverr
    );

endinterface

`default_nettype wire

/* src/apb_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_decoder (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cfgreg_pkg::paddr_t paddr,
    input  cfgreg_pkg::word_t  pwdata,
    output cfgreg_pkg::word_t  prdata,
    output logic               pready,
    output logic               pslverr,
    apb_intf.master            cfg_apb,
    apb_intf.master            remap_apb
);
    import cfgreg_pkg::*;

    region_t region;
    logic    region_hit;
    logic    unmapped_q;

    always_comb begin
        region     = paddr[15:12];
        region_hit = (region == REGION_CFG) || (region == REGION_REMAP);
    end

    // Only psel is qualified, the rest fans out to both slaves
    assign cfg_apb.psel    = psel & (region == REGION_CFG);
    assign cfg_apb.penable = penable;
    assign cfg_apb.pwrite  = pwrite;
    assign cfg_apb.paddr   = paddr;
    assign cfg_apb.pwdata  = pwdata;

    assign remap_apb.psel    = psel & (region == REGION_REMAP);
    assign remap_apb.penable = penable;
    assign remap_apb.pwrite  = pwrite;
    assign remap_apb.paddr   = paddr;
    assign remap_apb.pwdata  = pwdata;

    // Set at the end of an unmapped setup phase, so it is high for the access cycle only
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            unmapped_q <= 1'b0;
        end else begin
            unmapped_q <= psel & ~penable & ~region_hit;
        end
    end

    always_comb begin
        case (region)
            REGION_CFG: begin
                prdata  = cfg_apb.prdata;
                pready  = cfg_apb.pready;
                pslverr = cfg_apb.pslverr;
            end
            REGION_REMAP: begin
                prdata  = remap_apb.prdata;
                pready  = remap_apb.pready;
                pslverr = remap_apb.pslverr;
            end
            default: begin
                prdata  = '0;             // Unmapped space reads zero
                pready  = 1'b1;
                pslverr = unmapped_q;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/cfgreg.sv */
`timescale 1ns/1ns
`default_nettype none

module cfgreg (
    input  logic              clk,
    input  logic              rstn,
    apb_intf.slave            apb,
    output cfgreg_pkg::addr_t core_bootvec,
    output cfgreg_pkg::addr_t ddr_offset,
    output logic              core_rstn
);
    import cfgreg_pkg::*;

    word_t    rsv_reg0;
    word_t    rsv_reg1;
    word_t    rdata_c;
    reg_off_t off;
    logic     apb_wr;
    logic     apb_rd;

    always_comb begin
        off    = apb.paddr[11:0];
        apb_wr = apb.psel & ~apb.penable & apb.pwrite;    // Writes commit at the end of setup
        apb_rd = apb.psel & ~apb.penable & ~apb.pwrite;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            core_rstn    <= 1'b0;                          // Core held in reset until released
            core_bootvec <= BOOTVEC_RST;
            ddr_offset   <= DDR_OFFSET_RST;
            rsv_reg0     <= '0;
            rsv_reg1     <= '0;
        end else if (apb_wr) begin
            case (off)
                CFGREG_RSTN:      core_rstn    <= apb.pwdata[0];
                CFGREG_BOOTVEC:   core_bootvec <= apb.pwdata;
                CFGREG_DDROFFSET: ddr_offset   <= apb.pwdata;
                CFGREG_RSVREG0:   rsv_reg0     <= apb.pwdata;
                CFGREG_RSVREG1:   rsv_reg1     <= apb.pwdata;
                default: ;                                 // Version and holes ignore writes
            endcase
        end
    end

    always_comb begin
        case (off)
            CFGREG_RSTN:      rdata_c = {{31{1'b0}}, core_rstn};
            CFGREG_BOOTVEC:   rdata_c = core_bootvec;
            CFGREG_DDROFFSET: rdata_c = ddr_offset;
            CFGREG_RSVREG0:   rdata_c = rsv_reg0;
            CFGREG_RSVREG1:   rdata_c = rsv_reg1;
            CFGREG_VER:       rdata_c = RISCV_VER;
            default:          rdata_c = '0;
        endcase
    end

    // Captured with the setup edge, presented during access
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            apb.prdata <= '0;
        end else if (apb_rd) begin
            apb.prdata <= rdata_c;
        end
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = 1'b0;

endmodule

`default_nettype wire

/* src/ddr_remap.sv */
`timescale 1ns/1ns
`default_nettype none

module ddr_remap (
    input  logic              clk,
    input  logic              rstn,
    input  cfgreg_pkg::addr_t ddr_offset,
    input  logic              core_req_valid,
    input  cfgreg_pkg::addr_t core_req_addr,
    apb_intf.slave            apb,
    output logic              ddr_req_valid,
    output cfgreg_pkg::addr_t ddr_req_addr,
    output logic              remap_fault
);
    import cfgreg_pkg::*;

    addr_t    win_off;
    logic     in_win;
    cnt_t     hit_cnt;
    cnt_t     fault_cnt;
    addr_t    fault_addr;
    reg_off_t off;
    word_t    rdata_c;
    logic     apb_rd;
    logic     wr_err_q;

    // Addresses below the base wrap to large offsets and fall outside the window
    always_comb begin
        win_off = core_req_addr - DDR_WIN_BASE;
        in_win  = win_off < DDR_WIN_SIZE;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ddr_req_valid <= 1'b0;
            remap_fault   <= 1'b0;
        end else begin
            ddr_req_valid <= core_req_valid & in_win;
            remap_fault   <= core_req_valid & ~in_win;
        end
    end

    always_ff @(posedge clk) begin
        if (core_req_valid && in_win) begin
            ddr_req_addr <= ddr_offset + win_off;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hit_cnt    <= '0;
            fault_cnt  <= '0;
            fault_addr <= '0;
        end else if (core_req_valid) begin
            if (in_win) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                fault_cnt  <= fault_cnt + 1'b1;
                fault_addr <= core_req_addr;     // Keeps the most recent fault
            end
        end
    end

    always_comb begin
        off    = apb.paddr[11:0];
        apb_rd = apb.psel & ~apb.penable & ~apb.pwrite;
        case (off)
            REMAP_HITCNT:    rdata_c = hit_cnt;
            REMAP_FAULTCNT:  rdata_c = fault_cnt;
            REMAP_FAULTADDR: rdata_c = fault_addr;
            default:         rdata_c = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            apb.prdata <= '0;
            wr_err_q   <= 1'b0;
        end else begin
            wr_err_q <= apb.psel & ~apb.penable & apb.pwrite;   // Region is read only
            if (apb_rd) begin
                apb.prdata <= rdata_c;
            end
        end
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = wr_err_q;

endmodule

`default_nettype wire

/* src/cfg_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_subsys_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  cfgreg_pkg::paddr_t paddr,
    input  cfgreg_pkg::word_t  pwdata,
    output cfgreg_pkg::word_t  prdata,
    output logic               pready,
    output logic               pslverr,
    output cfgreg_pkg::addr_t  core_bootvec,
    output logic               core_rstn,
    input  logic               core_req_valid,
    input  cfgreg_pkg::addr_t  core_req_addr,
    output logic               ddr_req_valid,
    output cfgreg_pkg::addr_t  ddr_req_addr,
    output logic               remap_fault
);
    import cfgreg_pkg::*;

    addr_t ddr_offset;

    apb_intf apb_cfg ();
    apb_intf apb_remap ();

    apb_decoder u_apb_decoder (
        .clk       (clk),
        .rstn      (rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg_apb   (apb_cfg.master),
        .remap_apb (apb_remap.master)
    );

    cfgreg u_cfgreg (
        .clk          (clk),
        .rstn         (rstn),
        .apb          (apb_cfg.slave),
        .core_bootvec (core_bootvec),
        .ddr_offset   (ddr_offset),
        .core_rstn    (core_rstn)
    );

    ddr_remap u_ddr_remap (
        .clk            (clk),
        .rstn           (rstn),
        .ddr_offset     (ddr_offset),
        .core_req_valid (core_req_valid),
        .core_req_addr  (core_req_addr),
        .apb            (apb_remap.slave),
        .ddr_req_valid  (ddr_req_valid),
        .ddr_req_addr   (ddr_req_addr),
        .remap_fault    (remap_fault)
    );

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;            // 10 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;                   // Released just after the tenth edge
    end

endmodule

`default_nettype wire

/* verification/cfg_subsys_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_subsys_chk (
    input logic clk,
    input logic rstn,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic core_req_valid,
    input logic ddr_req_valid,
    input logic remap_fault,
    input logic core_rstn
);
    logic bad_ready = 1'b0;
    logic bad_err   = 1'b0;
    logic bad_excl  = 1'b0;
    logic bad_lat   = 1'b0;
    logic bad_rst   = 1'b0;
    logic fail_seen;                      // Sampled by the testbench at the end of the run

    assign fail_seen = bad_ready | bad_err | bad_excl | bad_lat | bad_rst;

    a_ready: assert property (@(posedge clk) disable iff (!rstn) penable |-> pready)
        else begin
            $error("pready low while penable is high");
            bad_ready = 1'b1;
        end

    a_err: assert property (@(posedge clk) disable iff (!rstn) !(psel && penable) |-> !pslverr)
        else begin
            $error("pslverr high outside an access phase");
            bad_err = 1'b1;
        end

    a_excl: assert property (@(posedge clk) disable iff (!rstn) !(ddr_req_valid && remap_fault))
        else begin
            $error("ddr_req_valid and remap_fault high together");
            bad_excl = 1'b1;
        end

    // Every request gives exactly one result on the next edge, and no result comes without one
    a_lat: assert property (@(posedge clk) disable iff (!rstn)
                            (ddr_req_valid || remap_fault) == $past(core_req_valid))
        else begin
            $error("remap result does not follow core_req_valid by one cycle");
            bad_lat = 1'b1;
        end

    a_rst: assert property (@(posedge clk) !rstn |-> !core_rstn)
        else begin
            $error("core_rstn released while rstn is low");
            bad_rst = 1'b1;
        end

endmodule

`default_nettype wire

/* verification/cfg_subsys_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cfg_subsys_tb;
    import cfgreg_pkg::*;

    localparam logic [1:0] K_WR  = 2'd0;
    localparam logic [1:0] K_RD  = 2'd1;
    localparam logic [1:0] K_REQ = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        addr_t      addr;                 // APB address in bits 15:0, or the core address
        word_t      data;
        word_t      exp;
        logic       err;                  // Expected pslverr, or expected remap_fault
    } row_t;

    logic   clk, rstn;
    logic   psel, penable, pwrite, pready, pslverr;
    paddr_t paddr;
    word_t  pwdata, prdata;
    logic   core_rstn, core_req_valid, ddr_req_valid, remap_fault;
    addr_t  core_bootvec, core_req_addr, ddr_req_addr;

    row_t   rows[$];
    int     n_rows = 0;
    int     err_cnt = 0;
    int     fail_rows = 0;
    integer seed = 41;
    addr_t  m_offset = 32'h2000_0000;     // Remap model that follows the table in order
    cnt_t   m_hits = '0;
    cnt_t   m_faults = '0;
    addr_t  m_fault_addr = '0;

    tb_clk_gen u_clk_gen (.clk(clk), .rstn(rstn));

    cfg_subsys_top dut (.*);

    bind cfg_subsys_top cfg_subsys_chk u_chk (
        .clk(clk), .rstn(rstn), .psel(psel), .penable(penable), .pready(pready),
        .pslverr(pslverr), .core_req_valid(core_req_valid), .ddr_req_valid(ddr_req_valid),
        .remap_fault(remap_fault), .core_rstn(core_rstn)
    );

    function automatic logic in_window(input addr_t a);
        return (a >= DDR_WIN_BASE) && (a < DDR_WIN_BASE + DDR_WIN_SIZE);
    endfunction

    function automatic addr_t outside_window(input addr_t a);
        return in_window(a) ? (a ^ 32'h4000_0000) : a;
    endfunction

    function automatic addr_t cfg_reg(input reg_off_t off);
        return {16'h0000, REGION_CFG, off};
    endfunction

    function automatic addr_t remap_reg(input reg_off_t off);
        return {16'h0000, REGION_REMAP, off};
    endfunction

    function automatic string row_name(input row_t r, input int idx);
        string kind;
        kind = (r.kind == K_WR) ? "write" : (r.kind == K_RD) ? "read" : "core req";
        return $sformatf("%0d %-8s %h", idx, kind, r.addr);
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t got);
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic add_row(input logic [1:0] kind, input addr_t addr, input word_t data,
                           input word_t exp, input logic err);
        row_t r;
        r = '{kind, addr, data, exp, err};
        rows.push_back(r);
    endtask

    // Hit maps to offset plus distance into the window, a miss is a fault
    task automatic add_req(input addr_t a);
        if (in_window(a)) begin
            add_row(K_REQ, a, '0, m_offset + (a - DDR_WIN_BASE), 1'b0);
            m_hits = m_hits + 1;
        end else begin
            add_row(K_REQ, a, '0, '0, 1'b1);
            m_faults = m_faults + 1;
            m_fault_addr = a;
        end
    endtask

    task automatic build_table();
        add_row(K_RD, cfg_reg(CFGREG_RSTN),      '0, 32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_BOOTVEC),   '0, 32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_DDROFFSET), '0, 32'h2000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSVREG0),   '0, 32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSVREG1),   '0, 32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_VER),       '0, 32'h0001_0200, 1'b0);
        add_row(K_WR, cfg_reg(CFGREG_RSTN),    32'hA5A5_A5A5, 32'h0000_0001, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSTN),    '0,            32'h0000_0001, 1'b0);
        add_row(K_WR, cfg_reg(CFGREG_BOOTVEC), 32'h0000_4000, 32'h0000_4000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_BOOTVEC), '0,            32'h0000_4000, 1'b0);
        add_row(K_WR, cfg_reg(CFGREG_RSVREG0), 32'hDEAD_BEEF, '0,            1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSVREG0), '0,            32'hDEAD_BEEF, 1'b0);
        add_row(K_WR, cfg_reg(CFGREG_RSVREG1), 32'h1234_5678, '0,            1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSVREG1), '0,            32'h1234_5678, 1'b0);
        add_row(K_WR, cfg_reg(CFGREG_RSTN),    32'hFFFF_FFFE, 32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSTN),    '0,            32'h0000_0000, 1'b0);
        add_row(K_WR, cfg_reg(CFGREG_VER),     32'hFFFF_FFFF, '0,            1'b0);
        add_row(K_RD, cfg_reg(CFGREG_VER),     '0,            32'h0001_0200, 1'b0);
        add_row(K_WR, cfg_reg(12'h018),        32'hFFFF_FFFF, '0,            1'b0);
        add_row(K_RD, cfg_reg(12'h018),        '0,            32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_BOOTVEC), '0,            32'h0000_4000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSTN),      '0, 32'h0000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_DDROFFSET), '0, 32'h2000_0000, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSVREG0),   '0, 32'hDEAD_BEEF, 1'b0);
        add_row(K_RD, cfg_reg(CFGREG_RSVREG1),   '0, 32'h1234_5678, 1'b0);
        add_row(K_RD, 32'h0000_2000,           '0,            32'h0000_0000, 1'b1);
        add_row(K_WR, 32'h0000_3004,           32'h0000_00FF, '0,            1'b1);
        add_row(K_RD, 32'h0000_F00C,           '0,            32'h0000_0000, 1'b1);
        add_row(K_WR, remap_reg(REMAP_HITCNT), 32'h0000_0055, '0,            1'b1);
        repeat (4) add_req(DDR_WIN_BASE | (addr_t'($random(seed)) & (DDR_WIN_SIZE - 1)));
        add_row(K_WR, cfg_reg(CFGREG_DDROFFSET), 32'h4000_0000, '0, 1'b0);
        m_offset = 32'h4000_0000;
        add_row(K_RD, cfg_reg(CFGREG_DDROFFSET), '0, 32'h4000_0000, 1'b0);
        repeat (4) add_req(DDR_WIN_BASE | (addr_t'($random(seed)) & (DDR_WIN_SIZE - 1)));
        add_req(32'h8FFF_FFFC);           // Last word of the window
        add_req(32'h9000_0000);
        add_req(32'h7FFF_FFFC);
        repeat (4) add_req(outside_window(addr_t'($random(seed))));
        add_row(K_WR, remap_reg(REMAP_FAULTCNT), 32'h0000_0000, '0, 1'b1);
        add_row(K_RD, remap_reg(REMAP_HITCNT),    '0, m_hits,       1'b0);
        add_row(K_RD, remap_reg(REMAP_FAULTCNT),  '0, m_faults,     1'b0);
        add_row(K_RD, remap_reg(REMAP_FAULTADDR), '0, m_fault_addr, 1'b0);
    endtask

    // Drives 1 ns after the edge and samples on the falling edge of the result cycle
    task automatic apply_row(input row_t r);
        @(posedge clk);
        #1;
        if (r.kind == K_REQ) begin
            core_req_valid = 1'b1;
            core_req_addr  = r.addr;
            @(posedge clk);
            #1;
            core_req_valid = 1'b0;
            @(negedge clk);
            check_bit("ddr_req_valid", ~r.err, ddr_req_valid);
            check_bit("remap_fault", r.err, remap_fault);
            if (!r.err) check_addr("ddr_req_addr", r.exp, ddr_req_addr);
        end else begin
            psel    = 1'b1;
            penable = 1'b0;
            pwrite  = (r.kind == K_WR);
            paddr   = r.addr[15:0];
            pwdata  = r.data;
            @(posedge clk);
            #1;
            penable = 1'b1;
            @(negedge clk);
            check_bit("pready", 1'b1, pready);
            check_bit("pslverr", r.err, pslverr);
            if (r.kind == K_RD) begin
                check_word("prdata", r.exp, prdata);
            end else if (r.addr == cfg_reg(CFGREG_RSTN)) begin
                check_bit("core_rstn", r.exp[0], core_rstn);
            end else if (r.addr == cfg_reg(CFGREG_BOOTVEC)) begin
                check_addr("core_bootvec", r.exp, core_bootvec);
            end
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic report_test(input string what, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %-28s ok", what);
        end else begin
            fail_rows = fail_rows + 1;
            $display("test %-28s FAILED", what);
        end
    endtask

    initial begin
        wait (n_rows > 0);
        repeat (n_rows * 4 + 100) @(posedge clk);
        $display("Watchdog expired before the stimulus table finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int errs_before;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        core_req_valid = 1'b0;
        core_req_addr  = '0;
        build_table();
        n_rows = rows.size();
        wait (rstn === 1'b1);
        @(negedge clk);
        errs_before = err_cnt;
        check_bit("core_rstn", 1'b0, core_rstn);
        check_addr("core_bootvec", '0, core_bootvec);
        check_bit("ddr_req_valid", 1'b0, ddr_req_valid);
        check_bit("remap_fault", 1'b0, remap_fault);
        check_bit("pslverr", 1'b0, pslverr);
        check_word("prdata", '0, prdata);
        report_test("reset outputs", errs_before);
        for (int i = 0; i < n_rows; i++) begin
            errs_before = err_cnt;
            apply_row(rows[i]);
            report_test(row_name(rows[i], i), errs_before);
        end
        if (dut.u_chk.fail_seen) $display("The bound checker saw assertion failures");
        $display("Summary: %0d tests, %0d failed, %0d check errors", n_rows + 1, fail_rows,
                 err_cnt);
        if (err_cnt == 0 && !dut.u_chk.fail_seen) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/cfgreg_pkg.sv
src/apb_intf.sv
src/apb_decoder.sv
src/cfgreg.sv
src/ddr_remap.sv
src/cfg_subsys_top.sv
verification/tb_clk_gen.sv
verification/cfg_subsys_chk.sv
verification/cfg_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module cfg_subsys_tb -f src.f --Mdir obj_dir -o cfg_subsys_sim; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so assertion failures do not stop the run early
sim_out=$(./obj_dir/cfg_subsys_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All tests passed" <<< "$sim_out"; then
    exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
